/* Makefile */
SIM := obj_dir/Vtb_dmiss
SRCS := $(wildcard logic/*.sv logic/*.svh tb/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dmiss \
		-f compile.f -o Vtb_dmiss

run: $(SIM)
	./$(SIM) | tee sim.log
	! grep -q "=== FAIL ===" sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
+incdir+logic
logic/dmiss_req_pkg.sv
logic/dmiss_entry_pkg.sv
logic/dmiss_fill_stage.sv
logic/dmiss_alloc.sv
logic/dmiss_entries.sv
logic/dmiss_replay.sv
logic/dmiss_top.sv
tb/tb_dmiss.sv

/* logic/dmiss_alloc.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmiss_macros.svh"

module dmiss_alloc (
  input  wire dmiss_req_pkg::fill_port_t                  staged_i,
  input  wire dmiss_entry_pkg::entry_mask_t               busy_i,
  output dmiss_entry_pkg::entry_mask_t                    wr_en_o,
  output dmiss_req_pkg::miss_info_t [`DM_ENTRIES-1:0]     wr_info_o,
  output logic                                            alloc_any_o
);

  import dmiss_entry_pkg::*;

  localparam int CNT_W = $clog2(`DM_ENTRIES) + 1;

  logic [CNT_W-1:0] free_cnt;
  logic [CNT_W-1:0] rank;     // ports granted so far.
  entry_mask_t      taken;
  logic             placed;

  always_comb begin
    free_cnt = '0;
    for (int e = 0; e < `DM_ENTRIES; e++) begin
      free_cnt = free_cnt + CNT_W'(!busy_i[e]);
    end
  end

  // ports in order, each takes the lowest entry still open.
  always_comb begin
    taken     = busy_i;
    rank      = '0;
    placed    = 1'b0;
    wr_en_o   = '0;
    wr_info_o = '0;
    for (int p = 0; p < `DM_PORTS; p++) begin
      if (staged_i[p].valid && rank < free_cnt) begin
        placed = 1'b0;
        for (int e = 0; e < `DM_ENTRIES; e++) begin
          if (!placed && !taken[e]) begin
            taken[e]     = 1'b1;
            wr_en_o[e]   = 1'b1;
            wr_info_o[e] = staged_i[p].info;
            placed       = 1'b1;
          end
        end
        rank = rank + CNT_W'(1);
      end
    end
    alloc_any_o = |wr_en_o;
  end

  // a live miss is never overwritten.
  always_comb begin
    a_no_busy_write: assert final ((wr_en_o & busy_i) == '0);
  end

endmodule

`default_nettype wire

/* logic/dmiss_entries.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmiss_macros.svh"

module dmiss_entries (
  input  wire logic                                     clk,
  input  wire logic                                     rst,
  input  wire dmiss_entry_pkg::entry_mask_t             wr_en_i,
  input  wire dmiss_req_pkg::miss_info_t [`DM_ENTRIES-1:0] wr_info_i,
  input  wire dmiss_req_pkg::fill_port_t                fill_i,
  input  wire dmiss_entry_pkg::entry_mask_t             read_sel_i,
  input  wire logic                                     ins_en_i,
  input  wire dmiss_entry_pkg::entry_idx_t              ins_idx_i,
  input  wire logic                                     unlock_i,
  output dmiss_entry_pkg::entry_mask_t                  busy_o,
  output dmiss_entry_pkg::entry_mask_t                  filled_o,
  output dmiss_entry_pkg::port_mask_t                   match_o,
  output dmiss_req_pkg::miss_info_t                     read_info_o,
  output logic [`DM_ADDR_W-1:0]                         ins_addr_o
);

  import dmiss_req_pkg::*;
  import dmiss_entry_pkg::*;

  miss_info_t [`DM_ENTRIES-1:0] entry_info;

  always_ff @(posedge clk) begin
    for (int e = 0; e < `DM_ENTRIES; e++) begin
      if (wr_en_i[e]) begin
        entry_info[e] <= wr_info_i[e];
      end
    end
  end

  // a write wins over insert and unlock in the same cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o   <= '0;
      filled_o <= '0;
    end else begin
      for (int e = 0; e < `DM_ENTRIES; e++) begin
        if (wr_en_i[e]) begin
          busy_o[e]   <= 1'b1;
          filled_o[e] <= 1'b1;
        end else begin
          if (ins_en_i && ins_idx_i == entry_idx_t'(e)) begin
            filled_o[e] <= 1'b0;  // looked up by insert.
          end
          if (unlock_i) begin
            busy_o[e] <= 1'b0;
          end
        end
      end
    end
  end

  // cam against every busy entry.
  always_comb begin
    for (int p = 0; p < `DM_PORTS; p++) begin
      match_o[p] = 1'b0;
      for (int e = 0; e < `DM_ENTRIES; e++) begin
        if (fill_i[p].valid && busy_o[e] && entry_info[e].addr == fill_i[p].info.addr) begin
          match_o[p] = 1'b1;
        end
      end
    end
  end

  // and-or mux, select is one-hot.
  always_comb begin
    read_info_o = '0;
    for (int e = 0; e < `DM_ENTRIES; e++) begin
      if (read_sel_i[e]) begin
        read_info_o = read_info_o | entry_info[e];
      end
    end
  end

  assign ins_addr_o = (ins_en_i && busy_o[ins_idx_i]) ? entry_info[ins_idx_i].addr : '0;

  a_read_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(read_sel_i));

endmodule

`default_nettype wire

/* logic/dmiss_entry_pkg.sv */
`default_nettype none

`include "dmiss_macros.svh"

package dmiss_entry_pkg;

  // one bit per entry.
  typedef logic [`DM_ENTRIES-1:0] entry_mask_t;

  typedef logic [$clog2(`DM_ENTRIES)-1:0] entry_idx_t;

  // one bit per fill port.
  typedef logic [`DM_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

/* logic/dmiss_fill_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmiss_macros.svh"

module dmiss_fill_stage (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire dmiss_req_pkg::fill_port_t   fill_i,
  input  wire dmiss_entry_pkg::port_mask_t match_i,
  input  wire logic                        fill_block_i,
  output dmiss_req_pkg::fill_port_t        staged_o
);

  import dmiss_req_pkg::*;
  import dmiss_entry_pkg::*;

  port_mask_t                    keep;
  port_mask_t                    staged_vld;
  miss_info_t [`DM_PORTS-1:0]    staged_info;
  logic                          staged_dup;

  // the highest port wins among equal addresses.
  always_comb begin
    for (int p = 0; p < `DM_PORTS; p++) begin
      keep[p] = fill_i[p].valid & ~match_i[p] & ~fill_block_i;
      for (int q = p + 1; q < `DM_PORTS; q++) begin
        if (fill_i[q].valid && fill_i[q].info.addr == fill_i[p].info.addr) begin
          keep[p] = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      staged_vld <= '0;
    end else begin
      staged_vld <= keep;
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `DM_PORTS; p++) begin
      staged_info[p] <= fill_i[p].info;
    end
  end

  always_comb begin
    for (int p = 0; p < `DM_PORTS; p++) begin
      staged_o[p].valid = staged_vld[p];
      staged_o[p].info  = staged_info[p];
    end
  end

  always_comb begin
    staged_dup = 1'b0;
    for (int p = 0; p < `DM_PORTS; p++) begin
      for (int q = p + 1; q < `DM_PORTS; q++) begin
        if (staged_vld[p] && staged_vld[q] &&
            staged_info[p].addr == staged_info[q].addr) begin
          staged_dup = 1'b1;
        end
      end
    end
  end

  // register never holds two copies of one line.
  a_staged_unique: assert property (@(posedge clk) disable iff (rst) !staged_dup);

endmodule

`default_nettype wire

/* logic/dmiss_macros.svh */
`ifndef DMISS_MACROS_SVH
`define DMISS_MACROS_SVH

// fill ports into the buffer.
`define DM_PORTS 4

// miss entries.
`define DM_ENTRIES 8

// line address, size and bank field widths.
`define DM_ADDR_W 36
`define DM_SZ_W 5
`define DM_BANK_W 5

`endif

/* logic/dmiss_replay.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmiss_macros.svh"

module dmiss_replay (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire dmiss_entry_pkg::entry_mask_t  busy_i,
  input  wire dmiss_entry_pkg::entry_mask_t  filled_i,
  input  wire logic                          alloc_any_i,
  input  wire logic                          unlock_i,
  output dmiss_entry_pkg::entry_mask_t       read_sel_o,
  output logic                               read_en_o,
  output dmiss_entry_pkg::entry_idx_t        read_idx_o,
  output logic                               fill_block_o,
  output logic                               has_free_o,
  output logic                               locked_o,
  output logic                               begin_replay_o
);

  import dmiss_entry_pkg::*;

  entry_mask_t issued;
  entry_mask_t cand;
  logic        started;  // fills seen since last replay.

  assign cand = busy_i & filled_i & ~issued;

  // lowest candidate.
  always_comb begin
    read_sel_o = cand & (~cand + entry_mask_t'(1));
    read_idx_o = '0;
    for (int e = `DM_ENTRIES - 1; e >= 0; e--) begin
      if (cand[e]) begin
        read_idx_o = entry_idx_t'(e);
      end
    end
  end

  assign read_en_o      = |cand;
  assign has_free_o     = ~&busy_i;
  assign begin_replay_o = started & ~|filled_i;
  assign fill_block_o   = locked_o | ~has_free_o | begin_replay_o;

  always_ff @(posedge clk) begin
    if (rst || unlock_i) begin
      issued <= '0;
    end else begin
      issued <= issued | read_sel_o;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      started  <= 1'b0;
      locked_o <= 1'b0;
    end else begin
      if (begin_replay_o) begin
        started <= 1'b0;
      end else if (alloc_any_i && !locked_o) begin
        started <= 1'b1;
      end
      locked_o <= fill_block_o & ~unlock_i;
    end
  end

  // fill register was blocked on the edge that set the lock.
  a_locked_no_alloc: assert property (@(posedge clk) disable iff (rst)
    locked_o |-> !alloc_any_i);

endmodule

`default_nettype wire

/* logic/dmiss_req_pkg.sv */
`default_nettype none

`include "dmiss_macros.svh"

package dmiss_req_pkg;

  // one miss as the pipeline hands it over.
  typedef struct packed {
    logic [`DM_ADDR_W-1:0] addr;  // line address.
    logic [`DM_SZ_W-1:0]   sz;
    logic [`DM_BANK_W-1:0] bank;
    logic [1:0]            low;
    logic                  st;    // store miss.
    logic                  io;
    logic                  split; // crosses a line.
    logic                  dupl;
    logic                  odd;
  } miss_info_t;

  typedef struct packed {
    logic       valid;
    miss_info_t info;
  } fill_req_t;

  // port 0 is the lowest numbered.
  typedef fill_req_t [`DM_PORTS-1:0] fill_port_t;

endpackage

`default_nettype wire

/* logic/dmiss_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmiss_macros.svh"

module dmiss_top (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire dmiss_req_pkg::fill_port_t    fill_i,
  input  wire logic                         ins_en_i,
  input  wire dmiss_entry_pkg::entry_idx_t  ins_idx_i,
  input  wire logic                         unlock_i,
  output logic [`DM_ADDR_W-1:0]             ins_addr_o,
  output logic                              read_en_o,
  output dmiss_entry_pkg::entry_idx_t       read_idx_o,
  output dmiss_req_pkg::miss_info_t         read_info_o,
  output logic                              has_free_o,
  output logic                              locked_o,
  output logic                              begin_replay_o
);

  import dmiss_req_pkg::*;
  import dmiss_entry_pkg::*;

  fill_port_t                    staged;
  port_mask_t                    match;
  logic                          fill_block;
  entry_mask_t                   wr_en;
  miss_info_t [`DM_ENTRIES-1:0]  wr_info;
  logic                          alloc_any;
  entry_mask_t                   busy;
  entry_mask_t                   filled;
  entry_mask_t                   read_sel;

  dmiss_fill_stage i_fill (
    .clk          (clk),
    .rst          (rst),
    .fill_i       (fill_i),
    .match_i      (match),
    .fill_block_i (fill_block),
    .staged_o     (staged)
  );

  dmiss_alloc i_alloc (
    .staged_i    (staged),
    .busy_i      (busy),
    .wr_en_o     (wr_en),
    .wr_info_o   (wr_info),
    .alloc_any_o (alloc_any)
  );

  dmiss_entries i_entries (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (wr_en),
    .wr_info_i   (wr_info),
    .fill_i      (fill_i),
    .read_sel_i  (read_sel),
    .ins_en_i    (ins_en_i),
    .ins_idx_i   (ins_idx_i),
    .unlock_i    (unlock_i),
    .busy_o      (busy),
    .filled_o    (filled),
    .match_o     (match),
    .read_info_o (read_info_o),
    .ins_addr_o  (ins_addr_o)
  );

  dmiss_replay i_replay (
    .clk            (clk),
    .rst            (rst),
    .busy_i         (busy),
    .filled_i       (filled),
    .alloc_any_i    (alloc_any),
    .unlock_i       (unlock_i),
    .read_sel_o     (read_sel),
    .read_en_o      (read_en_o),
    .read_idx_o     (read_idx_o),
    .fill_block_o   (fill_block),
    .has_free_o     (has_free_o),
    .locked_o       (locked_o),
    .begin_replay_o (begin_replay_o)
  );

endmodule

`default_nettype wire

/* tb/tb_dmiss.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dmiss_macros.svh"

module tb_dmiss;

  import dmiss_req_pkg::*;
  import dmiss_entry_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int READ_WAIT   = 20;
  localparam int NO_READ_WIN = 6;
  localparam int TEST_CYCLES = 5 * (10 + 70);

  logic                  clk;
  logic                  rst;
  fill_port_t            fill;
  logic                  ins_en;
  entry_idx_t            ins_idx;
  logic                  unlock;
  logic [`DM_ADDR_W-1:0] ins_addr;
  logic                  read_en;
  entry_idx_t            read_idx;
  miss_info_t            read_info;
  logic                  has_free;
  logic                  locked;
  logic                  begin_replay;
  int                    errors;
  int                    checks;

  dmiss_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .fill_i         (fill),
    .ins_en_i       (ins_en),
    .ins_idx_i      (ins_idx),
    .unlock_i       (unlock),
    .ins_addr_o     (ins_addr),
    .read_en_o      (read_en),
    .read_idx_o     (read_idx),
    .read_info_o    (read_info),
    .has_free_o     (has_free),
    .locked_o       (locked),
    .begin_replay_o (begin_replay)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #((TEST_CYCLES + 200) * CLK_PERIOD);
    $display("watchdog expired before the tests completed at %0t", $time);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic info_check(input string name, input miss_info_t got, input miss_info_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic idx_check(input string name, input entry_idx_t got, input entry_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %0d exp %0d", $time, name, got, exp);
    end
  endtask

  task automatic addr_check(input string name, input logic [`DM_ADDR_W-1:0] got,
                            input logic [`DM_ADDR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic level_check(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // tag keeps addresses distinct within a test.
  function automatic miss_info_t make_info(input logic [7:0] tag);
    miss_info_t m;
    logic [31:0] r0;
    logic [31:0] r1;
    r0 = $urandom;
    r1 = $urandom;
    m.addr  = {r0[27:0], tag};
    m.sz    = r1[4:0];
    m.bank  = r1[9:5];
    m.low   = r1[11:10];
    m.st    = r1[12];
    m.io    = r1[13];
    m.split = r1[14];
    m.dupl  = r1[15];
    m.odd   = r1[16];
    return m;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    rst     = 1'b1;
    fill    = '0;
    ins_en  = 1'b0;
    ins_idx = '0;
    unlock  = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
  endtask

  // one cycle of requests, then idle ports.
  task automatic send_fill(input fill_port_t f);
    @(negedge clk);
    fill = f;
    @(negedge clk);
    fill = '0;
  endtask

  task automatic wait_read(input int limit, output logic seen, output entry_idx_t idx,
                           output miss_info_t info);
    seen = 1'b0;
    idx  = '0;
    info = '0;
    for (int c = 0; c < limit && !seen; c++) begin
      @(negedge clk);
      if (read_en) begin
        seen = 1'b1;
        idx  = read_idx;
        info = read_info;
      end
    end
  endtask

  task automatic expect_read(input entry_idx_t exp_idx, input miss_info_t exp_info);
    logic       seen;
    entry_idx_t idx;
    miss_info_t info;
    wait_read(READ_WAIT, seen, idx, info);
    if (!seen) begin
      checks++;
      errors++;
      $display("no read of entry %0d came out by %0t", exp_idx, $time);
    end else begin
      idx_check("read_idx_o", idx, exp_idx);
      info_check("read_info_o", info, exp_info);
    end
  endtask

  task automatic expect_no_read();
    logic       seen;
    entry_idx_t idx;
    miss_info_t info;
    wait_read(NO_READ_WIN, seen, idx, info);
    checks++;
    if (seen) begin
      errors++;
      $display("unexpected read of entry %0d at %0t", idx, $time);
    end
  endtask

  task automatic lookup(input entry_idx_t idx, input logic [`DM_ADDR_W-1:0] exp);
    @(negedge clk);
    ins_en  = 1'b1;
    ins_idx = idx;
    #10;
    addr_check("ins_addr_o", ins_addr, exp);
    @(negedge clk);
    ins_en = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  task automatic single_fill();
    int         err0;
    fill_port_t f;
    miss_info_t a;
    err0 = errors;
    apply_reset();
    a = make_info(8'h11);
    f = '0;
    f[2].valid = 1'b1;
    f[2].info  = a;
    send_fill(f);
    expect_read(entry_idx_t'(0), a);
    expect_no_read();
    report_test("single_fill", err0);
  endtask

  task automatic same_cycle_dup();
    int         err0;
    fill_port_t f;
    miss_info_t a0;
    miss_info_t b1;
    miss_info_t a3;
    err0 = errors;
    apply_reset();
    a0 = make_info(8'h21);
    b1 = make_info(8'h22);
    a3 = make_info(8'h23);
    a3.addr = a0.addr;
    f = '0;
    f[0] = '{valid: 1'b1, info: a0};
    f[1] = '{valid: 1'b1, info: b1};
    f[3] = '{valid: 1'b1, info: a3};
    send_fill(f);
    // port 0 loses to port 3; allocation in port order puts port 1 first.
    expect_read(entry_idx_t'(0), b1);
    expect_read(entry_idx_t'(1), a3);
    expect_no_read();
    report_test("same_cycle_dup", err0);
  endtask

  task automatic cam_hit();
    int         err0;
    fill_port_t f;
    miss_info_t a;
    miss_info_t hit;
    miss_info_t c;
    err0 = errors;
    apply_reset();
    a = make_info(8'h31);
    f = '0;
    f[0] = '{valid: 1'b1, info: a};
    send_fill(f);
    expect_read(entry_idx_t'(0), a);
    hit = make_info(8'h32);
    hit.addr = a.addr;
    c = make_info(8'h33);
    f = '0;
    f[0] = '{valid: 1'b1, info: hit};
    f[1] = '{valid: 1'b1, info: c};
    send_fill(f);
    expect_read(entry_idx_t'(1), c);
    expect_no_read();
    report_test("cam_hit", err0);
  endtask

  task automatic insert_and_replay();
    int                      err0;
    fill_port_t              f;
    miss_info_t [2:0]        m;
    err0 = errors;
    apply_reset();
    f = '0;
    for (int p = 0; p < 3; p++) begin
      m[p] = make_info(8'h41 + 8'(p));
      f[p] = '{valid: 1'b1, info: m[p]};
    end
    send_fill(f);
    for (int e = 0; e < 3; e++) begin
      expect_read(entry_idx_t'(e), m[e]);
    end
    lookup(entry_idx_t'(5), '0);  // not busy.
    lookup(entry_idx_t'(0), m[0].addr);
    lookup(entry_idx_t'(1), m[1].addr);
    level_check("begin_replay_o", begin_replay, 1'b0);
    lookup(entry_idx_t'(2), m[2].addr);
    level_check("begin_replay_o", begin_replay, 1'b1);
    @(negedge clk);
    level_check("locked_o", locked, 1'b1);
    report_test("insert_and_replay", err0);
  endtask

  task automatic full_buffer_unlock();
    int                              err0;
    fill_port_t                      f;
    miss_info_t [`DM_ENTRIES-1:0]    m;
    miss_info_t                      late;
    err0 = errors;
    apply_reset();
    for (int e = 0; e < `DM_ENTRIES; e++) begin
      m[e] = make_info(8'h50 + 8'(e));
    end
    @(negedge clk);
    for (int p = 0; p < `DM_PORTS; p++) begin
      fill[p] = '{valid: 1'b1, info: m[p]};
    end
    @(negedge clk);
    for (int p = 0; p < `DM_PORTS; p++) begin
      fill[p] = '{valid: 1'b1, info: m[p + `DM_PORTS]};
    end
    @(negedge clk);
    fill = '0;
    // first batch is already reading out here.
    level_check("read_en_o", read_en, 1'b1);
    idx_check("read_idx_o", read_idx, entry_idx_t'(0));
    info_check("read_info_o", read_info, m[0]);
    for (int e = 1; e < `DM_ENTRIES; e++) begin
      expect_read(entry_idx_t'(e), m[e]);
    end
    level_check("has_free_o", has_free, 1'b0);
    level_check("locked_o", locked, 1'b1);
    f = '0;
    f[0] = '{valid: 1'b1, info: make_info(8'h60)};
    send_fill(f);
    expect_no_read();
    @(negedge clk);
    unlock = 1'b1;
    @(negedge clk);
    unlock = 1'b0;
    level_check("has_free_o", has_free, 1'b1);
    level_check("locked_o", locked, 1'b0);
    late = make_info(8'h61);
    f = '0;
    f[1] = '{valid: 1'b1, info: late};
    send_fill(f);
    expect_read(entry_idx_t'(0), late);
    report_test("full_buffer_unlock", err0);
  endtask

  initial begin
    void'($urandom(32'h320b));
    errors  = 0;
    checks  = 0;
    rst     = 1'b1;
    fill    = '0;
    ins_en  = 1'b0;
    ins_idx = '0;
    unlock  = 1'b0;
    single_fill();
    same_cycle_dup();
    cam_hit();
    insert_and_replay();
    full_buffer_unlock();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
